// ==== logic/bitscan_pkg.sv ====
// Bit-scan unit package with widths, opcodes and the pipeline stage structs
package bitscan_pkg;

    // ------------------------------
    // Widths and latency
    // ------------------------------
    localparam int DATA_WIDTH   = 32;
    localparam int INDEX_WIDTH  = $clog2(DATA_WIDTH);
    // One extra bit so a zero operand can report a count of 32
    localparam int COUNT_WIDTH  = INDEX_WIDTH + 1;
    localparam int TAG_WIDTH    = 4;
    // Decode, execute and result registers
    localparam int PIPE_LATENCY = 3;

    // Positions in the one-hot operation select
    localparam int NUM_OPS  = 5;
    localparam int SEL_FLS  = 0;
    localparam int SEL_FFS  = 1;
    localparam int SEL_CLZ  = 2;
    localparam int SEL_CTZ  = 3;
    localparam int SEL_NORM = 4;

    // Opcodes, codes 5 to 7 are illegal
    typedef enum logic [2:0] {
        op_fls  = 3'd0,
        op_ffs  = 3'd1,
        op_clz  = 3'd2,
        op_ctz  = 3'd3,
        op_norm = 3'd4
    } bitscan_op_e;

    // ------------------------------
    // Stage payloads
    // ------------------------------
    // Caller operation, 39 bits
    typedef struct packed {
        bitscan_op_e             opcode;
        logic [DATA_WIDTH-1:0]   operand;
        logic [TAG_WIDTH-1:0]    tag;
    } bitscan_req_t;

    // Decode to execute
    typedef struct packed {
        logic                    valid;
        logic [NUM_OPS-1:0]      sel;
        logic                    illegal;
        logic [DATA_WIDTH-1:0]   operand;
        logic [TAG_WIDTH-1:0]    tag;
    } decode_ctl_t;

    // Execute to result, every candidate value precomputed
    typedef struct packed {
        logic                    valid;
        logic [NUM_OPS-1:0]      sel;
        logic                    illegal;
        logic [TAG_WIDTH-1:0]    tag;
        logic                    zero;
        logic [INDEX_WIDTH-1:0]  fls_index;
        logic [INDEX_WIDTH-1:0]  ffs_index;
        logic [COUNT_WIDTH-1:0]  clz_count;
        logic [COUNT_WIDTH-1:0]  ctz_count;
        logic [DATA_WIDTH-1:0]   norm_value;
    } execute_out_t;

    // Result seen by the caller
    typedef struct packed {
        logic [DATA_WIDTH-1:0]   value;
        logic                    zero;
        logic                    illegal;
        logic [TAG_WIDTH-1:0]    tag;
    } bitscan_res_t;

endpackage : bitscan_pkg

// ==== logic/find_last_set.sv ====
// Find last set: combinational priority scan for the highest set bit index
`timescale 1ns/100ps

module find_last_set
    import bitscan_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH
) (
    input  logic [WIDTH-1:0]         data,
    output logic [$clog2(WIDTH)-1:0] index
);

    // Index width follows the scanned width
    localparam int IDX_W = $clog2(WIDTH);

    // ------------------------------
    // Priority scan
    // ------------------------------
    // Walk from the MSB toward bit 0
    // First one seen wins, lower bits ignored after that
    always_comb begin
        logic hit;

        hit   = 1'b0;
        // All-zero input falls through to index 0
        index = '0;

        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (!hit && data[i]) begin
                index = IDX_W'(i);
                hit   = 1'b1;
            end
        end
    end

    // Note: index 0 is ambiguous between "bit 0 set" and "no bit set"
    // Callers needing the difference test the operand for zero themselves

endmodule : find_last_set

// ==== logic/bitscan_decode.sv ====
// Bit-scan decode stage: registers the operation and expands its opcode
`timescale 1ns/100ps

module bitscan_decode
    import bitscan_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         op_valid,
    input  bitscan_req_t op,
    output decode_ctl_t  ctl
);

    // Next-cycle controls from the opcode
    logic [NUM_OPS-1:0] sel_next;
    logic               illegal_next;

    // ------------------------------
    // Opcode expansion
    // ------------------------------
    always_comb begin
        sel_next     = '0;
        illegal_next = 1'b0;

        case (op.opcode)
            op_fls:  sel_next[SEL_FLS]  = 1'b1;
            op_ffs:  sel_next[SEL_FFS]  = 1'b1;
            op_clz:  sel_next[SEL_CLZ]  = 1'b1;
            op_ctz:  sel_next[SEL_CTZ]  = 1'b1;
            op_norm: sel_next[SEL_NORM] = 1'b1;
            // Codes 5 to 7, no select bit
            default: illegal_next = 1'b1;
        endcase
    end

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk) begin
        // Only the valid bit is cleared
        if (reset) begin
            ctl.valid <= 1'b0;
        end else begin
            ctl.valid <= op_valid;
        end

        // Payload captured on the strobe only
        if (op_valid) begin
            ctl.sel     <= sel_next;
            ctl.illegal <= illegal_next;
            ctl.operand <= op.operand;
            ctl.tag     <= op.tag;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Valid op carries a single operation or the illegal marker, never both
    sel_onehot_a: assert property (
        @(posedge clk) disable iff (reset)
        ctl.valid |-> $onehot({ctl.sel, ctl.illegal})
    ) else $error("decode select not one-hot: sel=%b illegal=%b", ctl.sel, ctl.illegal);

endmodule : bitscan_decode

// ==== logic/bitscan_execute.sv ====
// Bit-scan execute stage: both scans, zero counts and normalize shift, registered
`timescale 1ns/100ps

module bitscan_execute
    import bitscan_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  decode_ctl_t  ctl,
    output execute_out_t exe
);

    // Scan inputs and raw indices
    logic [DATA_WIDTH-1:0]  reversed;
    logic [INDEX_WIDTH-1:0] fls_index;
    logic [INDEX_WIDTH-1:0] rev_index;

    // Derived values before the register
    logic                   zero;
    logic [INDEX_WIDTH-1:0] ffs_index;
    logic [INDEX_WIDTH-1:0] lead_zeros;
    logic [COUNT_WIDTH-1:0] clz_count;
    logic [COUNT_WIDTH-1:0] ctz_count;
    logic [DATA_WIDTH-1:0]  norm_value;

    // ------------------------------
    // Scanners
    // ------------------------------
    // Mirror the operand so the MSB scan finds the LSB
    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            reversed[i] = ctl.operand[DATA_WIDTH-1-i];
        end
    end

    find_last_set #(
        .WIDTH (DATA_WIDTH)
    ) u_fls_high (
        .data  (ctl.operand),
        .index (fls_index)
    );

    find_last_set #(
        .WIDTH (DATA_WIDTH)
    ) u_fls_low (
        .data  (reversed),
        .index (rev_index)
    );

    // ------------------------------
    // Counts and normalize
    // ------------------------------
    // Single source of the zero flag for the rest of the pipe
    assign zero = (ctl.operand == '0);

    // Mirrored index back to real position, 0 when nothing set
    assign ffs_index = zero ? '0 : INDEX_WIDTH'(DATA_WIDTH - 1) - rev_index;

    // 31 minus the top index
    assign lead_zeros = INDEX_WIDTH'(DATA_WIDTH - 1) - fls_index;

    // Full width reported on a zero operand
    assign clz_count = zero ? COUNT_WIDTH'(DATA_WIDTH) : COUNT_WIDTH'(lead_zeros);
    assign ctz_count = zero ? COUNT_WIDTH'(DATA_WIDTH) : COUNT_WIDTH'(ffs_index);

    // Zero operand shifts to zero anyway
    assign norm_value = ctl.operand << lead_zeros;

    // ------------------------------
    // Stage register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= ctl.valid;
        end

        if (ctl.valid) begin
            exe.sel        <= ctl.sel;
            exe.illegal    <= ctl.illegal;
            exe.tag        <= ctl.tag;
            exe.zero       <= zero;
            exe.fls_index  <= fls_index;
            exe.ffs_index  <= ffs_index;
            exe.clz_count  <= clz_count;
            exe.ctz_count  <= ctz_count;
            exe.norm_value <= norm_value;
        end
    end

    // Scan plus shift must land a one in the MSB for any nonzero operand
    norm_msb_a: assert property (
        @(posedge clk) disable iff (reset)
        (exe.valid && !exe.zero) |-> exe.norm_value[DATA_WIDTH-1]
    ) else $error("normalize lost MSB: value=%h", exe.norm_value);

endmodule : bitscan_execute

// ==== logic/bitscan_result.sv ====
// Bit-scan result stage: picks the requested value, sets flags, registers the output
`timescale 1ns/100ps

module bitscan_result
    import bitscan_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  execute_out_t exe,
    output logic         res_valid,
    output bitscan_res_t res
);

    // Selected value before the register
    logic [DATA_WIDTH-1:0] value_next;

    // ------------------------------
    // Value select
    // ------------------------------
    // AND-OR mux on the one-hot select, indices zero-extended
    always_comb begin
        value_next = ({DATA_WIDTH{exe.sel[SEL_FLS]}}  & DATA_WIDTH'(exe.fls_index))
                   | ({DATA_WIDTH{exe.sel[SEL_FFS]}}  & DATA_WIDTH'(exe.ffs_index))
                   | ({DATA_WIDTH{exe.sel[SEL_CLZ]}}  & DATA_WIDTH'(exe.clz_count))
                   | ({DATA_WIDTH{exe.sel[SEL_CTZ]}}  & DATA_WIDTH'(exe.ctz_count))
                   | ({DATA_WIDTH{exe.sel[SEL_NORM]}} & exe.norm_value);

        // Illegal opcode reports nothing
        if (exe.illegal) begin
            value_next = '0;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= exe.valid;
        end

        // Zero flag passes through from execute
        if (exe.valid) begin
            res.value   <= value_next;
            res.zero    <= exe.zero;
            res.illegal <= exe.illegal;
            res.tag     <= exe.tag;
        end
    end

    // Decode marks illegal, this stage clears the value; both must agree
    illegal_value_a: assert property (
        @(posedge clk) disable iff (reset)
        res_valid |-> !(res.illegal && (res.value != '0))
    ) else $error("illegal result with value %h, tag %h", res.value, res.tag);

endmodule : bitscan_result

// ==== logic/bitscan_unit.sv ====
// Bit-scan unit top: three-stage pipe of decode, execute and result
`timescale 1ns/100ps

module bitscan_unit
    import bitscan_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // Caller side, one strobe per operation
    input  logic         op_valid,
    input  bitscan_req_t op,
    // Result side, one pulse per operation, in order
    output logic         res_valid,
    output bitscan_res_t res
);

    // ------------------------------
    // Stage links
    // ------------------------------
    decode_ctl_t  ctl;
    execute_out_t exe;

    // Cycle 1, opcode expanded
    bitscan_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .op       (op),
        .ctl      (ctl)
    );

    // Cycle 2, scans and counts
    bitscan_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .ctl   (ctl),
        .exe   (exe)
    );

    // Cycle 3, value select and flags
    bitscan_result u_result (
        .clk       (clk),
        .reset     (reset),
        .exe       (exe),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule : bitscan_unit

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset source: free-running clock, reset held for a few cycles
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    // Clock starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : tb_clock_gen

// ==== sim/bitscan_unit_tb.sv ====
// Bit-scan unit testbench: directed tests against a reference model of the result rules
`timescale 1ns/100ps

module bitscan_unit_tb
    import bitscan_pkg::*;
;

    // ------------------------------
    // Run length and watchdog
    // ------------------------------
    localparam int CLK_PERIOD = 40;
    localparam int GAP_OPS    = 20;
    localparam int MAX_GAP    = 4;
    localparam int RAND_OPS   = 200;
    localparam int TOTAL_OPS  = 5 * DATA_WIDTH + 5 + 4 + RAND_OPS + GAP_OPS;
    // Ops, gap cycles, drain per test, idle test and reset, then margin
    localparam int WATCHDOG_CYCLES = TOTAL_OPS + GAP_OPS * MAX_GAP
                                   + 6 * (PIPE_LATENCY + 8) + 200;

    logic         clk;
    logic         reset;
    logic         op_valid;
    bitscan_req_t op;
    logic         res_valid;
    bitscan_res_t res;

    // Expected results and their due cycles, in issue order
    bitscan_res_t exp_res_q[$];
    int           exp_cycle_q[$];

    int     cycle_count;
    int     error_count;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (5)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    bitscan_unit uut (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op        (op),
        .res_valid (res_valid),
        .res       (res)
    );

    // Counts rising edges, read before the update at each edge
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic bitscan_res_t expected_result(input logic [2:0] code,
                                                     input logic [DATA_WIDTH-1:0] operand,
                                                     input logic [TAG_WIDTH-1:0] tag);
        bitscan_res_t r;
        int           hi;
        int           lo;
        logic         found;

        hi    = 0;
        lo    = 0;
        found = 1'b0;
        // Highest set bit is the last one seen, lowest the first
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (operand[i]) begin
                hi = i;
                if (!found) lo = i;
                found = 1'b1;
            end
        end
        r.zero    = (operand == '0);
        r.tag     = tag;
        r.illegal = 1'b0;
        case (code)
            3'd0:    r.value = hi;
            3'd1:    r.value = lo;
            3'd2:    r.value = r.zero ? DATA_WIDTH : (DATA_WIDTH - 1 - hi);
            3'd3:    r.value = r.zero ? DATA_WIDTH : lo;
            3'd4:    r.value = r.zero ? '0 : (operand << (DATA_WIDTH - 1 - hi));
            default: begin
                r.value   = '0;
                r.illegal = 1'b1;
            end
        endcase
        return r;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic show_mismatch(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                                 input logic [DATA_WIDTH-1:0] got_val);
        error_count++;
        $display("Fail %s: expected %h, got %h", name, exp_val, got_val);
    endtask

    task automatic check_result(input bitscan_res_t exp_res, input bitscan_res_t got_res);
        if (got_res.value !== exp_res.value) show_mismatch("res.value", exp_res.value, got_res.value);
        if (got_res.zero !== exp_res.zero) show_mismatch("res.zero", exp_res.zero, got_res.zero);
        if (got_res.illegal !== exp_res.illegal)
            show_mismatch("res.illegal", exp_res.illegal, got_res.illegal);
        if (got_res.tag !== exp_res.tag) show_mismatch("res.tag", exp_res.tag, got_res.tag);
    endtask

    task automatic check_latency(input int due_cycle, input int seen_cycle);
        if (seen_cycle != due_cycle) show_mismatch("res_valid cycle", due_cycle, seen_cycle);
    endtask

    // Result monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (res_valid !== 1'b0 && res_valid !== 1'b1) begin
                error_count++;
                $display("res_valid is unknown after reset at cycle %0d", cycle_count);
            end else if (res_valid) begin
                if (exp_res_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected result pulse at cycle %0d, tag %h", cycle_count, res.tag);
                end else begin
                    check_result(exp_res_q.pop_front(), res);
                    check_latency(exp_cycle_q.pop_front(), cycle_count);
                end
            end
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic issue_op(input logic [2:0] code, input logic [DATA_WIDTH-1:0] operand,
                            input logic [TAG_WIDTH-1:0] tag);
        bitscan_req_t req;

        req.opcode  = bitscan_op_e'(code);
        req.operand = operand;
        req.tag     = tag;
        @(posedge clk);
        op_valid <= 1'b1;
        op       <= req;
        // Sampled at the next edge, result due PIPE_LATENCY edges later
        exp_res_q.push_back(expected_result(code, operand, tag));
        exp_cycle_q.push_back(cycle_count + 1 + PIPE_LATENCY);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            op_valid <= 1'b0;
        end
    endtask

    // Wait for outstanding results, bounded by the pipe depth
    task automatic drain_results();
        int waited;

        waited = 0;
        while (exp_res_q.size() != 0 && waited < PIPE_LATENCY + 4) begin
            idle_cycles(1);
            waited++;
        end
        if (exp_res_q.size() != 0) begin
            error_count++;
            $display("%0d operations never returned a result", exp_res_q.size());
            exp_res_q.delete();
            exp_cycle_q.delete();
        end
        // A few quiet cycles to catch stray pulses
        idle_cycles(3);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%-24s : ok", name);
        end else begin
            tests_failed++;
            $display("%-24s : %0d errors", name, error_count - errors_before);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_idle_after_reset();
        int start;

        start = error_count;
        idle_cycles(10);
        finish_test("idle after reset", start);
    endtask

    task automatic test_single_bits();
        int start;

        start = error_count;
        for (int code = 0; code < 5; code++) begin
            for (int pos = 0; pos < DATA_WIDTH; pos++) begin
                issue_op(3'(code), DATA_WIDTH'(1) << pos, TAG_WIDTH'(pos));
            end
        end
        drain_results();
        finish_test("single bit operands", start);
    endtask

    task automatic test_zero_operand();
        int start;

        start = error_count;
        for (int code = 0; code < 5; code++) begin
            issue_op(3'(code), '0, TAG_WIDTH'(code + 3));
        end
        drain_results();
        finish_test("zero operand", start);
    endtask

    task automatic test_illegal_opcodes();
        int start;

        start = error_count;
        issue_op(3'd5, 32'h0000_0f00, 4'ha);
        issue_op(3'd6, 32'h8000_0001, 4'hb);
        issue_op(3'd7, 32'h1234_5678, 4'hc);
        // Zero flag still follows the operand
        issue_op(3'd7, '0, 4'hd);
        drain_results();
        finish_test("illegal opcodes", start);
    endtask

    task automatic test_random_back_to_back();
        int start;

        start = error_count;
        for (int i = 0; i < RAND_OPS; i++) begin
            issue_op(3'($unsigned($random(seed)) % 5), $random(seed), TAG_WIDTH'(i));
        end
        drain_results();
        finish_test("random back to back", start);
    endtask

    task automatic test_gapped_strobes();
        int start;

        start = error_count;
        for (int i = 0; i < GAP_OPS; i++) begin
            issue_op(3'($unsigned($random(seed)) % 5), $random(seed), TAG_WIDTH'(i));
            idle_cycles(($unsigned($random(seed)) % MAX_GAP) + 1);
        end
        drain_results();
        finish_test("gapped strobes", start);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        op_valid     = 1'b0;
        op           = '0;
        cycle_count  = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed         = 57;

        wait (reset === 1'b0);
        test_idle_after_reset();
        test_single_bits();
        test_zero_operand();
        test_illegal_opcodes();
        test_random_back_to_back();
        test_gapped_strobes();

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule : bitscan_unit_tb

// ==== files.f ====
logic/bitscan_pkg.sv
logic/find_last_set.sv
logic/bitscan_decode.sv
logic/bitscan_execute.sv
logic/bitscan_result.sv
logic/bitscan_unit.sv
sim/tb_clock_gen.sv
sim/bitscan_unit_tb.sv
